/* verilog/mpls_egress_settings.svh */
/* Build-time sizing of the egress path. EGR_PORT_BITS must name every port, and
   EGR_FIFO_DEPTH must be at least EGR_MAX_PKT_BEATS or no packet is ever admitted */

`ifndef MPLS_EGRESS_SETTINGS_SVH
`define MPLS_EGRESS_SETTINGS_SVH

// Physical egress ports, all 8 bits wide
`define EGR_NUM_PORTS 3
`define EGR_PORT_BITS 2

// Wide bus from the forwarding pipeline
`define EGR_BUS_BYTES 8

// Per-port buffering
`define EGR_FIFO_DEPTH 16
`define EGR_MAX_PKT_BEATS 4

`endif

/* verilog/mpls_egress_pkg.sv */
/* Beat, byte and adapter state types for the egress path.
   keep must be contiguous from byte 0 and nonzero */

`include "mpls_egress_settings.svh"

package mpls_egress_pkg;

    // One beat of the wide bus, egress index still attached
    typedef struct packed {
        logic [`EGR_BUS_BYTES*8-1:0] data;
        logic [`EGR_BUS_BYTES-1:0]   keep;
        logic                        last;
        logic [`EGR_PORT_BITS-1:0]   port;
    } egr_beat_t;

    // Same beat once the demux has stripped the index
    typedef struct packed {
        logic [`EGR_BUS_BYTES*8-1:0] data;
        logic [`EGR_BUS_BYTES-1:0]   keep;
        logic                        last;
    } port_beat_t;

    // One byte on a narrow physical port
    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } port_byte_t;

    typedef enum logic [1:0] {
        ADAPT_IDLE,
        ADAPT_FETCH,
        ADAPT_SHIFT
    } adapt_state_e;

endpackage

/* verilog/egress_demux.sv */
/* Routes each beat to one port strobe one cycle after beat_valid.
   Indices at or above EGR_NUM_PORTS are discarded and flagged on bad_port */

`timescale 1ns/100ps
`include "mpls_egress_settings.svh"
`default_nettype none

module egress_demux (
    input  wire logic                        clk,
    input  wire logic                        reset,
    input  wire logic                        beat_valid,
    input  wire mpls_egress_pkg::egr_beat_t  beat,
    output logic [`EGR_NUM_PORTS-1:0]        port_strobe,
    output mpls_egress_pkg::port_beat_t      port_beat,
    output logic                             bad_port
);

    ////////////////////
    // Index decode

    always_ff @(posedge clk) begin
        if (reset) begin
            port_strobe <= '0;
            bad_port    <= 1'b0;
        end else begin
            for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
                port_strobe[p] <= beat_valid && (beat.port == `EGR_PORT_BITS'(p));
            end
            // Index names a port that is not built
            bad_port <= beat_valid && (beat.port >= `EGR_PORT_BITS'(`EGR_NUM_PORTS));
        end
    end

    ////////////////////
    // Payload

    // Shared by every buffer, qualified by its own strobe
    always_ff @(posedge clk) begin
        if (beat_valid) begin
            port_beat.data <= beat.data;
            port_beat.keep <= beat.keep;
            port_beat.last <= beat.last;
        end
    end

endmodule

`default_nettype wire

/* verilog/egress_port_buffer.sv */
/* Beat FIFO for one port. A packet is admitted at its first beat only if room for
   the longest packet remains; otherwise all of its beats are dropped */

`timescale 1ns/100ps
`include "mpls_egress_settings.svh"
`default_nettype none

module egress_port_buffer (
    input  wire logic                        clk,
    input  wire logic                        reset,
    input  wire logic                        wr_strobe,
    input  wire mpls_egress_pkg::port_beat_t wr_beat,
    input  wire logic                        pop,
    output logic                             fifo_empty,
    output mpls_egress_pkg::port_beat_t      head,
    output logic                             buf_overflow
);

    localparam int PTR_W = $clog2(`EGR_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`EGR_FIFO_DEPTH + 1);
    // Highest fill level that still leaves room for a whole packet
    localparam int ADMIT_LIMIT = `EGR_FIFO_DEPTH - `EGR_MAX_PKT_BEATS;

    mpls_egress_pkg::port_beat_t mem [`EGR_FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             in_pkt;
    logic             dropping;
    logic             first_beat;
    logic             room;
    logic             push;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(`EGR_FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    ////////////////////
    // Admission

    assign first_beat = wr_strobe && !in_pkt;
    assign room       = (count <= CNT_W'(ADMIT_LIMIT));

    // Later beats follow the decision taken at the first one
    assign push = wr_strobe && (first_beat ? room : !dropping);

    // One pulse per refused packet
    assign buf_overflow = first_beat && !room;

    always_ff @(posedge clk) begin
        if (reset) begin
            in_pkt   <= 1'b0;
            dropping <= 1'b0;
        end else if (wr_strobe) begin
            in_pkt <= !wr_beat.last;
            if (first_beat) begin
                dropping <= !room;
            end
        end
    end

    ////////////////////
    // Storage

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head follows the read pointer, so it moves the cycle after a pop
    assign head       = mem[rd_ptr];
    assign fifo_empty = (count == '0);

endmodule

`default_nettype wire

/* verilog/egress_width_adapt.sv */
/* Serializes buffered beats into bytes, byte 0 first, one per cycle.
   The port has no back-pressure and a beat costs its kept bytes plus one cycle */

`timescale 1ns/100ps
`include "mpls_egress_settings.svh"
`default_nettype none

module egress_width_adapt (
    input  wire logic                        clk,
    input  wire logic                        reset,
    input  wire logic                        fifo_empty,
    input  wire mpls_egress_pkg::port_beat_t head,
    output logic                             pop,
    output logic                             byte_valid,
    output mpls_egress_pkg::port_byte_t      port_byte
);

    localparam int CNT_W = $clog2(`EGR_BUS_BYTES + 1);

    mpls_egress_pkg::adapt_state_e state;

    logic [`EGR_BUS_BYTES*8-1:0] shift_data;
    logic [`EGR_BUS_BYTES-1:0]   shift_keep;
    logic                        shift_last;
    logic [CNT_W-1:0]            bytes_left;
    logic                        final_byte;
    logic                        load;

    function automatic logic [CNT_W-1:0] kept_bytes(input logic [`EGR_BUS_BYTES-1:0] keep);
        logic [CNT_W-1:0] n;
        n = '0;
        for (int i = 0; i < `EGR_BUS_BYTES; i++) begin
            n = n + CNT_W'(keep[i]);
        end
        return n;
    endfunction

    assign final_byte = (state == mpls_egress_pkg::ADAPT_SHIFT) && (bytes_left == CNT_W'(1));

    // Take the next beat when idle or straight after the last byte of this one
    assign load = ((state == mpls_egress_pkg::ADAPT_IDLE) || final_byte) && !fifo_empty;
    assign pop  = load;

    ////////////////////
    // FSM

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= mpls_egress_pkg::ADAPT_IDLE;
            bytes_left <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= (state == mpls_egress_pkg::ADAPT_SHIFT);
            case (state)
                mpls_egress_pkg::ADAPT_IDLE: begin
                    if (load) begin
                        state <= mpls_egress_pkg::ADAPT_FETCH;
                    end
                end
                // Count of kept bytes settles from the latched keep
                mpls_egress_pkg::ADAPT_FETCH: begin
                    bytes_left <= kept_bytes(shift_keep);
                    state      <= mpls_egress_pkg::ADAPT_SHIFT;
                end
                mpls_egress_pkg::ADAPT_SHIFT: begin
                    bytes_left <= bytes_left - 1'b1;
                    if (final_byte) begin
                        state <= load ? mpls_egress_pkg::ADAPT_FETCH
                                      : mpls_egress_pkg::ADAPT_IDLE;
                    end
                end
                default: state <= mpls_egress_pkg::ADAPT_IDLE;
            endcase
        end
    end

    ////////////////////
    // Datapath

    always_ff @(posedge clk) begin
        if (load) begin
            shift_data <= head.data;
            shift_keep <= head.keep;
            shift_last <= head.last;
        end else if (state == mpls_egress_pkg::ADAPT_SHIFT) begin
            shift_data <= shift_data >> 8;
        end
        port_byte.data <= shift_data[7:0];
        port_byte.last <= shift_last && final_byte;
    end

endmodule

`default_nettype wire

/* verilog/mpls_egress.sv */
/* Egress side of the router for 8-bit ports only, all in one clock domain.
   No back-pressure anywhere; congestion shows only as whole-packet drops */

`timescale 1ns/100ps
`include "mpls_egress_settings.svh"
`default_nettype none

module mpls_egress (
    input  wire logic                        clk,
    input  wire logic                        reset,
    input  wire logic                        beat_valid,
    input  wire mpls_egress_pkg::egr_beat_t  beat,
    output logic [`EGR_NUM_PORTS-1:0]        byte_valid,
    output mpls_egress_pkg::port_byte_t      port_bytes [`EGR_NUM_PORTS-1:0],
    output logic [`EGR_NUM_PORTS-1:0]        buf_overflow,
    output logic                             bad_port
);

    logic [`EGR_NUM_PORTS-1:0]   port_strobe;
    mpls_egress_pkg::port_beat_t port_beat;
    logic [`EGR_NUM_PORTS-1:0]   fifo_empty;
    logic [`EGR_NUM_PORTS-1:0]   pop;
    mpls_egress_pkg::port_beat_t head [`EGR_NUM_PORTS-1:0];

    ////////////////////
    // Demux

    egress_demux demux (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .beat_valid  ( beat_valid  ),
        .beat        ( beat        ),
        .port_strobe ( port_strobe ),
        .port_beat   ( port_beat   ),
        .bad_port    ( bad_port    )
    );

    ////////////////////
    // Per-port logic

    // Buffer then serializer for each physical port
    for (genvar p = 0; p < `EGR_NUM_PORTS; p++) begin : g_port
        egress_port_buffer port_buffer (
            .clk          ( clk             ),
            .reset        ( reset           ),
            .wr_strobe    ( port_strobe[p]  ),
            .wr_beat      ( port_beat       ),
            .pop          ( pop[p]          ),
            .fifo_empty   ( fifo_empty[p]   ),
            .head         ( head[p]         ),
            .buf_overflow ( buf_overflow[p] )
        );

        egress_width_adapt width_adapt (
            .clk        ( clk           ),
            .reset      ( reset         ),
            .fifo_empty ( fifo_empty[p] ),
            .head       ( head[p]       ),
            .pop        ( pop[p]        ),
            .byte_valid ( byte_valid[p] ),
            .port_byte  ( port_bytes[p] )
        );
    end

endmodule

`default_nettype wire

/* tests/mpls_egress_tb.sv */
/* Seeded random packets against a per-port byte model. Drops are resolved by skipping
   expected packets, so their number must equal the buf_overflow pulses of that port */

`timescale 1ns/100ps
`include "mpls_egress_settings.svh"

module mpls_egress_tb;

    localparam int LIGHT_GAP  = 8;
    localparam int ROUTE_PKTS = 12;
    localparam int BAD_PKTS   = 6;
    localparam int CONG_PKTS  = 20;
    localparam int FLUSH_PKTS = 2;
    localparam int RESET_PKTS = 6;
    localparam int ISO_PKTS   = 24;
    localparam int P2_SPACING = 48;
    localparam int TOTAL_PKTS = ROUTE_PKTS + 2 * BAD_PKTS + CONG_PKTS + FLUSH_PKTS
                              + RESET_PKTS + 2 * ISO_PKTS;
    localparam int MAX_PKT_BYTES  = `EGR_MAX_PKT_BEATS * `EGR_BUS_BYTES;
    localparam int TIMEOUT_CYCLES = TOTAL_PKTS * MAX_PKT_BYTES * 3 + 1000;

    logic                               clk;
    logic                               reset;
    logic                               beat_valid;
    mpls_egress_pkg::egr_beat_t         beat;
    logic [`EGR_NUM_PORTS-1:0]          byte_valid;
    mpls_egress_pkg::port_byte_t        port_bytes [`EGR_NUM_PORTS-1:0];
    logic [`EGR_NUM_PORTS-1:0]          buf_overflow;
    logic                               bad_port;

    integer seed = 61;
    int     cycle_cnt = 0;
    int     errors;
    int     tests_run;
    int     tests_failed;
    int     test_start_errors;
    int     ovf_cnt [`EGR_NUM_PORTS];
    int     skipped [`EGR_NUM_PORTS];
    int     bad_cnt;
    int     bad_exp;
    int     last_p2;

    // Expected bytes per port, cut into packets by exp_lens
    logic [7:0] exp_bytes [`EGR_NUM_PORTS][$];
    int         exp_lens  [`EGR_NUM_PORTS][$];
    logic [7:0] got_bytes [`EGR_NUM_PORTS][$];

    mpls_egress uut (
        .clk          ( clk          ),
        .reset        ( reset        ),
        .beat_valid   ( beat_valid   ),
        .beat         ( beat         ),
        .byte_valid   ( byte_valid   ),
        .port_bytes   ( port_bytes   ),
        .buf_overflow ( buf_overflow ),
        .bad_port     ( bad_port     )
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the DUT did not deliver all traffic within %0d cycles",
                     TIMEOUT_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    ////////////////////
    // Reference model

    // Resolve one collected packet against the head of the expected queue
    task automatic match_packet(input int p);
        bit found;
        bit same;
        int n;
        found = 1'b0;
        while (!found && exp_lens[p].size() > 0) begin
            n = exp_lens[p][0];
            same = (n == got_bytes[p].size());
            for (int i = 0; i < n && same; i++) begin
                same = (exp_bytes[p][i] == got_bytes[p][i]);
            end
            if (same) begin
                found = 1'b1;
            end else begin
                skipped[p]++;
            end
            repeat (n) begin
                void'(exp_bytes[p].pop_front());
            end
            void'(exp_lens[p].pop_front());
        end
        assert (found) else begin
            $display("Port %0d delivered a %0d byte packet that matches no packet sent to it",
                     p, got_bytes[p].size());
            errors++;
        end
        got_bytes[p].delete();
    endtask

    // Bytes are stable at the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
                if (buf_overflow[p]) begin
                    ovf_cnt[p]++;
                end
                if (byte_valid[p]) begin
                    got_bytes[p].push_back(port_bytes[p].data);
                    if (port_bytes[p].last) begin
                        match_packet(p);
                    end
                end
            end
            if (bad_port) begin
                bad_cnt++;
            end
        end
    end

    function automatic bit drained();
        if (byte_valid != '0) begin
            return 1'b0;
        end
        // Whatever is still expected must be accounted for by drop pulses
        for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
            if (exp_lens[p].size() != ovf_cnt[p] - skipped[p]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // Packets cut short by a reset leave the model without being delivered
    task automatic flush_model();
        for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
            exp_bytes[p].delete();
            exp_lens[p].delete();
            got_bytes[p].delete();
            ovf_cnt[p] = 0;
            skipped[p] = 0;
        end
        bad_cnt = 0;
        bad_exp = 0;
    endtask

    ////////////////////
    // Stimulus

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            beat_valid <= 1'b0;
        end
    endtask

    task automatic send_packet(input int port, input int nbeats, input int gap);
        logic [`EGR_BUS_BYTES*8-1:0] data;
        logic [`EGR_BUS_BYTES-1:0]   keep;
        int                          nkeep;
        int                          len;
        len = 0;
        for (int b = 0; b < nbeats; b++) begin
            for (int w = 0; w < `EGR_BUS_BYTES / 4; w++) begin
                data[32*w +: 32] = $random(seed);
            end
            nkeep = (b == nbeats - 1) ? 1 + rand_below(`EGR_BUS_BYTES) : `EGR_BUS_BYTES;
            keep = {`EGR_BUS_BYTES{1'b1}} >> (`EGR_BUS_BYTES - nkeep);
            if (port < `EGR_NUM_PORTS) begin
                for (int i = 0; i < nkeep; i++) begin
                    exp_bytes[port].push_back(data[8*i +: 8]);
                end
                len += nkeep;
                if (b == nbeats - 1) begin
                    exp_lens[port].push_back(len);
                end
            end else begin
                bad_exp++;
            end
            @(posedge clk);
            beat_valid <= 1'b1;
            beat <= '{data: data, keep: keep, last: (b == nbeats - 1),
                      port: `EGR_PORT_BITS'(port)};
            idle(gap);
        end
    endtask

    function automatic int rand_len();
        return 1 + rand_below(`EGR_MAX_PKT_BEATS);
    endfunction

    ////////////////////
    // Test control

    task automatic check_quiet();
        assert (byte_valid == '0) else begin
            $display("ERR byte_valid = 0x%0h, expected 0x0", byte_valid);
            errors++;
        end
        assert (buf_overflow == '0) else begin
            $display("ERR buf_overflow = 0x%0h, expected 0x0", buf_overflow);
            errors++;
        end
        assert (bad_port == 1'b0) else begin
            $display("ERR bad_port = 0x%0h, expected 0x0", bad_port);
            errors++;
        end
    endtask

    // Caller raises reset; held for 3 cycles, then 2 more cycles watched
    task automatic hold_reset();
        for (int i = 0; i < 5; i++) begin
            @(posedge clk);
            if (i == 2) begin
                reset <= 1'b0;
            end
            @(negedge clk);
            check_quiet();
        end
    endtask

    task automatic begin_test();
        test_start_errors = errors;
        bad_cnt = 0;
        bad_exp = 0;
        for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
            ovf_cnt[p] = 0;
            skipped[p] = 0;
        end
    endtask

    task automatic drain_and_check();
        idle(1);
        while (!drained()) begin
            @(negedge clk);
        end
        for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
            // Trailing packets never delivered count as drops
            while (exp_lens[p].size() > 0) begin
                repeat (exp_lens[p][0]) begin
                    void'(exp_bytes[p].pop_front());
                end
                void'(exp_lens[p].pop_front());
                skipped[p]++;
            end
            assert (skipped[p] == ovf_cnt[p]) else begin
                $display("ERR buf_overflow[%0d] pulses = 0x%0h, missing packets = 0x%0h",
                         p, ovf_cnt[p], skipped[p]);
                errors++;
            end
        end
        assert (bad_cnt == bad_exp) else begin
            $display("ERR bad_port pulses = 0x%0h, expected 0x%0h", bad_cnt, bad_exp);
            errors++;
        end
    endtask

    task automatic no_drops(input int p);
        assert (ovf_cnt[p] == 0) else begin
            $display("ERR buf_overflow[%0d] pulses = 0x%0h, expected 0x0", p, ovf_cnt[p]);
            errors++;
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors == test_start_errors) begin
            $display("Test %0d %s: PASS", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: FAIL", tests_run, name);
        end
    endtask

    initial begin
        reset <= 1'b1;
        beat_valid <= 1'b0;
        beat <= '0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        begin_test();
        hold_reset();
        report_test("power-on reset");

        begin_test();
        for (int i = 0; i < ROUTE_PKTS; i++) begin
            send_packet(rand_below(`EGR_NUM_PORTS), rand_len(), LIGHT_GAP);
        end
        drain_and_check();
        for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
            no_drops(p);
        end
        report_test("routing and serialization");

        begin_test();
        for (int i = 0; i < BAD_PKTS; i++) begin
            send_packet(rand_below(`EGR_NUM_PORTS), rand_len(), LIGHT_GAP);
            send_packet(`EGR_NUM_PORTS, rand_len(), LIGHT_GAP);
        end
        drain_and_check();
        report_test("bad port index");

        begin_test();
        for (int i = 0; i < CONG_PKTS; i++) begin
            send_packet(1, rand_len(), 0);
        end
        drain_and_check();
        assert (ovf_cnt[1] > 0) else begin
            $display("Port 1 dropped no packet although it was flooded back to back");
            errors++;
        end
        report_test("congestion drop");

        // Reset lands while port 0 still holds beats and is serializing
        begin_test();
        for (int i = 0; i < FLUSH_PKTS; i++) begin
            send_packet(0, `EGR_MAX_PKT_BEATS, 0);
        end
        @(posedge clk);
        reset <= 1'b1;
        beat_valid <= 1'b0;
        hold_reset();
        flush_model();
        for (int i = 0; i < RESET_PKTS; i++) begin
            send_packet(rand_below(`EGR_NUM_PORTS), rand_len(), LIGHT_GAP);
        end
        drain_and_check();
        for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
            no_drops(p);
        end
        report_test("reset state");

        // Port 2 gets a packet only once its previous one has had time to drain
        begin_test();
        last_p2 = cycle_cnt - P2_SPACING;
        for (int i = 0; i < ISO_PKTS; i++) begin
            send_packet(0, rand_len(), 0);
            if (cycle_cnt - last_p2 >= P2_SPACING) begin
                last_p2 = cycle_cnt;
                send_packet(2, rand_len(), 0);
            end
        end
        drain_and_check();
        no_drops(2);
        report_test("port isolation");

        $display("Tests run: %0d, tests failed: %0d, failed checks: %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* mpls_egress.f */
+incdir+verilog
verilog/mpls_egress_pkg.sv
verilog/egress_demux.sv
verilog/egress_port_buffer.sv
verilog/egress_width_adapt.sv
verilog/mpls_egress.sv
tests/mpls_egress_tb.sv
